//--- list.f
+incdir+.
mesh_dir_pkg.sv
mesh_flit_pkg.sv
mesh_fifo_small.sv
mesh_route_decode.sv
mesh_rr_arbiter.sv
mesh_router.sv
mesh_router_buffered.sv
tb_mesh_router_buffered.sv

//--- tb_mesh_router_buffered.sv
`include "mesh_params.svh"

module tb_mesh_router_buffered
   import mesh_dir_pkg::*;
   import mesh_flit_pkg::*;
();

   localparam int my_x_lp        = 3;
   localparam int my_y_lp        = 3;
   localparam int src_width_lp   = 3;
   localparam int seq_width_lp   = payload_width_lp - src_width_lp;
   localparam int coord_max_lp   = (1 << `MESH_X_CORD_WIDTH) - 1;

   // test lengths in cycles
   localparam int reset_cycles_lp  = 5;
   localparam int single_cycles_lp = DIRS * 25 * 4;
   localparam int rand_cycles_lp   = 300;
   localparam int drain_limit_lp   = 40;
   localparam int bp_limit_lp      = 20;
   localparam int bp_hold_lp       = 8;
   localparam int fair_warm_lp     = 10;
   localparam int fair_cycles_lp   = 40;
   localparam int stim_cycles_lp   = reset_cycles_lp + single_cycles_lp
                                   + 2 * (rand_cycles_lp + 1 + drain_limit_lp)
                                   + bp_limit_lp + bp_hold_lp + drain_limit_lp
                                   + fair_warm_lp + fair_cycles_lp + 1 + drain_limit_lp;
   localparam int timeout_cycles_lp = 4 * stim_cycles_lp + 200;

   logic                           clk_i;
   logic                           reset_i;
   logic  [DIRS-1:0]               v_i;
   flit_u [DIRS-1:0]               data_i;
   logic  [DIRS-1:0]               ready_o;
   logic  [DIRS-1:0]               v_o;
   flit_u [DIRS-1:0]               data_o;
   logic  [DIRS-1:0]               ready_i;
   logic  [`MESH_X_CORD_WIDTH-1:0] my_x_i;
   logic  [`MESH_Y_CORD_WIDTH-1:0] my_y_i;

   // expected flits, one queue per source and output pair
   logic [`MESH_WIDTH-1:0] exp_q [DIRS*DIRS][$];
   logic [`MESH_WIDTH-1:0] held_data [DIRS];
   logic [DIRS-1:0]        held_v = '0;
   int                     accepted [DIRS];
   int                     fair_q [$];
   bit                     fair_window = 1'b0;
   int                     outstanding = 0;
   int                     mismatch_count = 0;
   int                     other_count = 0;
   int                     cycle_count = 0;

   mesh_router_buffered mesh_router_buffered_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (v_i),
      .data_i  (data_i),
      .ready_o (ready_o),
      .v_o     (v_o),
      .data_o  (data_o),
      .ready_i (ready_i),
      .my_x_i  (my_x_i),
      .my_y_i  (my_y_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // expected output port for a flit entering this tile
   function automatic int route_of(input flit_u f);
      int dx;
      int dy;
      int x_dir;
      int y_dir;
      dx    = int'(f.hdr.dest_x) - my_x_lp;
      dy    = int'(f.hdr.dest_y) - my_y_lp;
      x_dir = (dx > 0) ? int'(E) : int'(W);
      y_dir = (dy > 0) ? int'(S) : int'(N);
      if (dx == 0 && dy == 0) begin
         return int'(P);
      end
      if (dx == 0) begin
         return y_dir;
      end
      if (dy == 0) begin
         return x_dir;
      end
      return (`MESH_XY_ORDER != 0) ? x_dir : y_dir;
   endfunction

   function automatic flit_u make_flit(input int src, input int seq, input int dx, input int dy);
      flit_u f;
      f.hdr.dest_x  = `MESH_X_CORD_WIDTH'(dx);
      f.hdr.dest_y  = `MESH_Y_CORD_WIDTH'(dy);
      f.hdr.payload = {src_width_lp'(src), seq_width_lp'(seq)};
      return f;
   endfunction

   function automatic flit_u rand_flit(input int src);
      return make_flit(src, accepted[src], $urandom_range(coord_max_lp, 0),
                       $urandom_range(coord_max_lp, 0));
   endfunction

   function automatic int src_of(input flit_u f);
      return int'(f.hdr.payload[payload_width_lp-1 -: src_width_lp]);
   endfunction

   // near and far coordinates on both sides of the tile
   function automatic int coord_of(input int k);
      case (k)
         0:       return 0;
         1:       return 2;
         2:       return 3;
         3:       return 4;
         default: return 7;
      endcase
   endfunction

   // inputs settle 1 unit after the edge, so the falling edge sees the next handshake
   always @(negedge clk_i) begin : compare
      int                     out;
      int                     src;
      logic                   ok;
      logic [`MESH_WIDTH-1:0] want;
      if (reset_i) begin
         for (int s = 0; s < DIRS; s++) begin
            if (v_i[s] && ready_o[s]) begin
               out = route_of(data_i[s]);
               exp_q[s * DIRS + out].push_back(data_i[s].raw);
               accepted[s]++;
               outstanding++;
            end
         end
         for (int o = 0; o < DIRS; o++) begin
            if (held_v[o]) begin
               assert (v_o[o]) else begin
                  other_count++;
                  $display("v_o[%0d] dropped at time %0t before its flit was taken", o, $time);
               end
               assert (data_o[o].raw == held_data[o]) else begin
                  mismatch_count++;
                  $display("mismatch at time %0t: data_o[%0d] got %h expected %h",
                           $time, o, data_o[o].raw, held_data[o]);
               end
            end
            held_v[o]    = v_o[o] && !ready_i[o];
            held_data[o] = data_o[o].raw;
            if (v_o[o] && ready_i[o]) begin
               src = src_of(data_o[o]);
               if (fair_window && o == int'(P)) begin
                  fair_q.push_back(src);
               end
               ok = (src < DIRS) && (exp_q[src * DIRS + o].size() != 0);
               assert (ok) else begin
                  other_count++;
                  $display("flit %h left on port %0d at time %0t but none was expected there",
                           data_o[o].raw, o, $time);
               end
               if (ok) begin
                  want = exp_q[src * DIRS + o].pop_front();
                  outstanding--;
                  assert (data_o[o].raw == want) else begin
                     mismatch_count++;
                     $display("mismatch at time %0t: data_o[%0d] got %h expected %h",
                              $time, o, data_o[o].raw, want);
                  end
               end
            end
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles_lp) begin
         other_count++;
         $display("run stopped by timeout after %0d cycles", cycle_count);
         $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (outstanding != 0 && waited < drain_limit_lp) begin
         @(posedge clk_i);
         #1;
         waited++;
      end
      assert (outstanding == 0) else begin
         other_count++;
         $display("%0d flits still inside the router after %0d cycles", outstanding, waited);
      end
   endtask

   task automatic send_single(input int src, input int dx, input int dy);
      int base;
      base = accepted[src];
      @(posedge clk_i);
      #1;
      v_i[src]    = 1'b1;
      data_i[src] = make_flit(src, accepted[src], dx, dy);
      while (accepted[src] == base) begin
         @(posedge clk_i);
         #1;
      end
      v_i[src] = 1'b0;
      wait_drain();
   endtask

   task automatic random_traffic(input int cycles, input bit toggle_ready);
      for (int c = 0; c < cycles; c++) begin
         @(posedge clk_i);
         #1;
         for (int s = 0; s < DIRS; s++) begin
            v_i[s]    = ($urandom_range(9, 0) < 7);
            data_i[s] = rand_flit(s);
            if (toggle_ready) begin
               ready_i[s] = ($urandom_range(9, 0) < 6);
            end
         end
      end
      @(posedge clk_i);
      #1;
      v_i     = '0;
      ready_i = '1;
      wait_drain();
   endtask

   // input S floods a blocked east output
   task automatic back_pressure();
      int base;
      int waited;
      @(posedge clk_i);
      #1;
      ready_i[E] = 1'b0;
      base       = accepted[S];
      waited     = 0;
      v_i[S]     = 1'b1;
      data_i[S]  = make_flit(S, accepted[S], my_x_lp + 2, my_y_lp);
      while (ready_o[S] && waited < bp_limit_lp) begin
         @(posedge clk_i);
         #1;
         data_i[S] = make_flit(S, accepted[S], my_x_lp + 2, my_y_lp);
         waited++;
      end
      assert (!ready_o[S]) else begin
         other_count++;
         $display("ready_o[0] never fell while the east output was blocked");
      end
      repeat (bp_hold_lp) begin
         @(posedge clk_i);
         #1;
         assert (v_o[E]) else begin
            other_count++;
            $display("v_o[2] is low at time %0t while a flit waits for the blocked east output",
                     $time);
         end
      end
      assert (accepted[S] - base == `MESH_FIFO_ELS) else begin
         mismatch_count++;
         $display("mismatch at time %0t: flits taken by ready_o[0] got %0d expected %0d",
                  $time, accepted[S] - base, `MESH_FIFO_ELS);
      end
      v_i[S]     = 1'b0;
      ready_i[E] = 1'b1;
      wait_drain();
   endtask

   task automatic fairness();
      logic [DIRS-1:0] seen;
      for (int c = 0; c < fair_warm_lp + fair_cycles_lp; c++) begin
         @(posedge clk_i);
         #1;
         fair_window = (c >= fair_warm_lp);
         for (int s = int'(S); s <= int'(W); s++) begin
            v_i[s]    = 1'b1;
            data_i[s] = make_flit(s, accepted[s], my_x_lp, my_y_lp);
         end
      end
      @(posedge clk_i);
      #1;
      fair_window = 1'b0;
      v_i         = '0;
      wait_drain();
      assert (fair_q.size() >= fair_cycles_lp / 2) else begin
         other_count++;
         $display("only %0d flits left on port P while it was saturated", fair_q.size());
      end
      for (int i = 0; i + DIRS <= fair_q.size(); i++) begin
         seen = '0;
         for (int k = 0; k < DIRS; k++) begin
            seen[fair_q[i + k]] = 1'b1;
         end
         assert (seen[3:0] == 4'hf) else begin
            other_count++;
            $display("a source was skipped on port P in outputs %0d to %0d", i, i + DIRS - 1);
         end
      end
   endtask

   initial begin : stimulus
      void'($urandom(30229));
      reset_i = 1'b0;
      v_i     = '0;
      data_i  = '0;
      ready_i = '1;
      my_x_i  = `MESH_X_CORD_WIDTH'(my_x_lp);
      my_y_i  = `MESH_Y_CORD_WIDTH'(my_y_lp);
      for (int s = 0; s < DIRS; s++) begin
         accepted[s] = 0;
      end
      repeat (reset_cycles_lp) @(posedge clk_i);
      #1;
      reset_i = 1'b1;
      assert (v_o == '0 && ready_o == '1) else begin
         other_count++;
         $display("tile was not empty and open right after reset");
      end

      for (int s = 0; s < DIRS; s++) begin
         for (int xi = 0; xi < 5; xi++) begin
            for (int yi = 0; yi < 5; yi++) begin
               send_single(s, coord_of(xi), coord_of(yi));
            end
         end
      end
      random_traffic(rand_cycles_lp, 1'b0);
      back_pressure();
      fairness();
      random_traffic(rand_cycles_lp, 1'b1);

      for (int q = 0; q < DIRS * DIRS; q++) begin
         assert (exp_q[q].size() == 0) else begin
            other_count++;
            $display("%0d flits from input %0d to output %0d never left the router",
                     exp_q[q].size(), q / DIRS, q % DIRS);
         end
      end
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count + other_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- mesh_router_buffered.sv
`include "mesh_params.svh"

module mesh_router_buffered
   import mesh_dir_pkg::*;
   import mesh_flit_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          reset_i,

   input  logic  [DIRS-1:0]              v_i,
   input  flit_u [DIRS-1:0]              data_i,
   output logic  [DIRS-1:0]              ready_o,

   output logic  [DIRS-1:0]              v_o,
   output flit_u [DIRS-1:0]              data_o,
   input  logic  [DIRS-1:0]              ready_i,

   input  logic  [`MESH_X_CORD_WIDTH-1:0] my_x_i,
   input  logic  [`MESH_Y_CORD_WIDTH-1:0] my_y_i
);

   logic  [DIRS-1:0] fifo_v;
   flit_u [DIRS-1:0] fifo_data;
   logic  [DIRS-1:0] fifo_yumi;

   // one buffer per inbound link
   for (genvar i = 0; i < DIRS; i++) begin : g_fifo
      mesh_fifo_small #(
         .els_p (`MESH_FIFO_ELS)
      ) fifo (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .v_i     (v_i[i]),
         .data_i  (data_i[i]),
         .ready_o (ready_o[i]),
         .v_o     (fifo_v[i]),
         .data_o  (fifo_data[i]),
         .yumi_i  (fifo_yumi[i])
      );
   end

   mesh_router router (
      .clk_i,
      .reset_i,
      .v_i     (fifo_v),
      .data_i  (fifo_data),
      .yumi_o  (fifo_yumi),
      .v_o     (v_o),
      .data_o  (data_o),
      .ready_i (ready_i),
      .my_x_i,
      .my_y_i
   );

   // tile comes out of reset empty and open
   reset_state_a: assert property (@(posedge clk_i)
      !reset_i |=> ((ready_o == '1) && (v_o == '0)));

endmodule

//--- mesh_router.sv
`include "mesh_params.svh"

module mesh_router
   import mesh_dir_pkg::*;
   import mesh_flit_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          reset_i,

   input  logic  [DIRS-1:0]              v_i,
   input  flit_u [DIRS-1:0]              data_i,
   output logic  [DIRS-1:0]              yumi_o,

   output logic  [DIRS-1:0]              v_o,
   output flit_u [DIRS-1:0]              data_o,
   input  logic  [DIRS-1:0]              ready_i,

   input  logic  [`MESH_X_CORD_WIDTH-1:0] my_x_i,
   input  logic  [`MESH_Y_CORD_WIDTH-1:0] my_y_i
);

   // decoder output, indexed [input][output]
   logic [DIRS-1:0][DIRS-1:0] dec_req;
   // arbiter side, indexed [output][input]
   logic [DIRS-1:0][DIRS-1:0] req_by_out;
   logic [DIRS-1:0][DIRS-1:0] grant;
   logic [DIRS-1:0]           xfer;

   for (genvar i = 0; i < DIRS; i++) begin : g_in
      mesh_route_decode decode (
         .dest_x_i (data_i[i].hdr.dest_x),
         .dest_y_i (data_i[i].hdr.dest_y),
         .my_x_i   (my_x_i),
         .my_y_i   (my_y_i),
         .req_o    (dec_req[i])
      );
   end

   // only a valid head competes
   always_comb begin
      for (int o = 0; o < DIRS; o++) begin
         for (int i = 0; i < DIRS; i++) begin
            req_by_out[o][i] = v_i[i] & dec_req[i][o];
         end
      end
   end

   for (genvar o = 0; o < DIRS; o++) begin : g_out
      mesh_rr_arbiter arb (
         .clk_i     (clk_i),
         .reset_i   (reset_i),
         .req_i     (req_by_out[o]),
         .grant_o   (grant[o]),
         .advance_i (xfer[o])
      );

      assign v_o[o]  = |grant[o];
      assign xfer[o] = v_o[o] & ready_i[o];

      // a waiting output keeps its flit
      hold_a: assert property (@(posedge clk_i) disable iff (!reset_i)
         (v_o[o] && !ready_i[o]) |=> (v_o[o] && $stable(data_o[o])));
   end

   // and-or crossbar, grants are one-hot
   always_comb begin
      for (int o = 0; o < DIRS; o++) begin
         data_o[o].raw = '0;
         for (int i = 0; i < DIRS; i++) begin
            if (grant[o][i]) begin
               data_o[o].raw = data_o[o].raw | data_i[i].raw;
            end
         end
      end
   end

   // each head requests one output, so at most one term is set
   always_comb begin
      yumi_o = '0;
      for (int o = 0; o < DIRS; o++) begin
         for (int i = 0; i < DIRS; i++) begin
            yumi_o[i] = yumi_o[i] | (grant[o][i] & xfer[o]);
         end
      end
   end

endmodule

//--- mesh_rr_arbiter.sv
module mesh_rr_arbiter
   import mesh_dir_pkg::*;
(
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic [DIRS-1:0] req_i,
   output logic [DIRS-1:0] grant_o,
   input  logic            advance_i
);

   localparam int ptr_width_lp = $clog2(DIRS);

   logic [ptr_width_lp-1:0] ptr_r;
   logic [ptr_width_lp-1:0] grant_idx;
   logic                    grant_any;

   // first requester at or after the pointer, cyclic
   always_comb begin
      int idx;
      grant_o   = '0;
      grant_idx = ptr_r;
      grant_any = 1'b0;
      for (int off = 0; off < DIRS; off++) begin
         idx = int'(ptr_r) + off;
         if (idx >= DIRS) begin
            idx = idx - DIRS;
         end
         if (!grant_any && req_i[idx]) begin
            grant_o[idx] = 1'b1;
            grant_idx    = ptr_width_lp'(idx);
            grant_any    = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         ptr_r <= S;
      end else if (advance_i) begin
         ptr_r <= (grant_idx == ptr_width_lp'(DIRS - 1)) ? '0 : grant_idx + 1'b1;
      end else if (grant_any) begin
         // park on a waiting winner, a later
         // requester cannot steal the output
         ptr_r <= grant_idx;
      end
   end

   grant_legal_a: assert property (@(posedge clk_i) disable iff (!reset_i)
      $onehot0(grant_o) && ((grant_o & ~req_i) == '0));

   // the core only advances on a real transfer
   advance_granted_a: assert property (@(posedge clk_i) disable iff (!reset_i)
      advance_i |-> grant_any);

endmodule

//--- mesh_route_decode.sv
`include "mesh_params.svh"

module mesh_route_decode
   import mesh_dir_pkg::*;
(
   input  logic [`MESH_X_CORD_WIDTH-1:0] dest_x_i,
   input  logic [`MESH_Y_CORD_WIDTH-1:0] dest_y_i,
   input  logic [`MESH_X_CORD_WIDTH-1:0] my_x_i,
   input  logic [`MESH_Y_CORD_WIDTH-1:0] my_y_i,
   output logic [DIRS-1:0]               req_o
);

   localparam bit xy_order_lp = (`MESH_XY_ORDER != 0);

   logic x_more;
   logic x_less;
   logic y_more;
   logic y_less;
   dir_e dir;

   assign x_more = (dest_x_i > my_x_i);
   assign x_less = (dest_x_i < my_x_i);
   assign y_more = (dest_y_i > my_y_i);
   assign y_less = (dest_y_i < my_y_i);

   // larger y lies to the south
   always_comb begin
      dir = P;
      if (xy_order_lp) begin
         if (x_more) dir = E;
         else if (x_less) dir = W;
         else if (y_more) dir = S;
         else if (y_less) dir = N;
      end else begin
         if (y_more) dir = S;
         else if (y_less) dir = N;
         else if (x_more) dir = E;
         else if (x_less) dir = W;
      end
   end

   always_comb begin
      req_o      = '0;
      req_o[dir] = 1'b1;
   end

endmodule

//--- mesh_fifo_small.sv
`include "mesh_params.svh"

module mesh_fifo_small
   import mesh_flit_pkg::*;
#(
   parameter int els_p = `MESH_FIFO_ELS
) (
   input  logic  clk_i,
   input  logic  reset_i,
   input  logic  v_i,
   input  flit_u data_i,
   output logic  ready_o,
   output logic  v_o,
   output flit_u data_o,
   input  logic  yumi_i
);

   localparam int ptr_width_lp   = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int count_width_lp = $clog2(els_p + 1);

   logic [`MESH_WIDTH-1:0]    mem [els_p];
   logic [ptr_width_lp-1:0]   wr_ptr_r;
   logic [ptr_width_lp-1:0]   rd_ptr_r;
   logic [count_width_lp-1:0] count_r;
   logic                      enq;
   logic                      deq;

   function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] ptr);
      return (ptr == ptr_width_lp'(els_p - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // full and empty come from the count alone
   assign ready_o    = (count_r != count_width_lp'(els_p));
   assign v_o        = (count_r != '0);
   assign enq        = v_i & ready_o;
   assign deq        = yumi_i;
   assign data_o.raw = mem[rd_ptr_r];

   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (enq) begin
            wr_ptr_r <= ptr_inc(wr_ptr_r);
         end
         if (deq) begin
            rd_ptr_r <= ptr_inc(rd_ptr_r);
         end
         case ({enq, deq})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (enq) begin
         mem[wr_ptr_r] <= data_i.raw;
      end
   end

   // router core must only consume a present head
   yumi_valid_a: assert property (@(posedge clk_i) disable iff (!reset_i) yumi_i |-> v_o);

   count_bound_a: assert property (@(posedge clk_i) disable iff (!reset_i)
      count_r <= count_width_lp'(els_p));

endmodule

//--- mesh_flit_pkg.sv
`include "mesh_params.svh"

package mesh_flit_pkg;

   // payload takes whatever the coordinates leave over
   localparam int payload_width_lp =
      `MESH_WIDTH - `MESH_X_CORD_WIDTH - `MESH_Y_CORD_WIDTH;

   // routing header, destination in the high bits
   typedef struct packed {
      logic [`MESH_Y_CORD_WIDTH-1:0] dest_y;
      logic [`MESH_X_CORD_WIDTH-1:0] dest_x;
      logic [payload_width_lp-1:0]   payload;
   } flit_hdr_s;

   // one flit word, decoded by the router as hdr
   // and moved around by the buffers as raw
   typedef union packed {
      flit_hdr_s              hdr;
      logic [`MESH_WIDTH-1:0] raw;
   } flit_u;

endpackage

//--- mesh_dir_pkg.sv
package mesh_dir_pkg;

   // number of router ports
   localparam int DIRS = 5;

   // port order is SNEWP, value doubles as the port index
   typedef enum logic [2:0] {
      S = 3'd0,
      N = 3'd1,
      E = 3'd2,
      W = 3'd3,
      P = 3'd4
   } dir_e;

endpackage

//--- mesh_params.svh
`ifndef MESH_PARAMS_SVH
`define MESH_PARAMS_SVH

// flit width in bits
`define MESH_WIDTH 16

// tile coordinate widths
`define MESH_X_CORD_WIDTH 3
`define MESH_Y_CORD_WIDTH 3

// entries per input FIFO
`define MESH_FIFO_ELS 2

// 1 routes X first, 0 routes Y first
`define MESH_XY_ORDER 1

`endif
